//--- common/buzzer_pkg.sv
package buzzer_pkg;

    localparam int num_records        = 8;
    localparam int code_bits          = 5;
    localparam int symbols_per_record = code_bits + 1; // five code bits, then one gap.
    localparam int repeat_w           = 4;

    typedef logic [code_bits-1:0]      record_t;
    typedef record_t [num_records-1:0] record_bank_t;
    typedef logic [2:0]                rec_idx_t;
    typedef logic [3:0]                count_t;       // 0 to 8 loaded records.
    typedef logic [repeat_w-1:0]       repeat_t;

    typedef enum logic [1:0] {
        normal   = 2'b00,
        slow     = 2'b01,
        fast     = 2'b10,
        fast_alt = 2'b11  // same timing as fast.
    } speed_t;

    typedef enum logic [1:0] {
        gap_symbol = 2'b00,
        short_tone = 2'b01,
        long_tone  = 2'b10
    } symbol_kind_t;

    typedef struct packed {
        logic     start;       // one-cycle pulse.
        logic     all_records;
        rec_idx_t first_rec;
        rec_idx_t last_rec;
    } play_cmd_t;

    typedef struct packed {
        logic         load;    // one-cycle pulse.
        symbol_kind_t kind;
    } tone_cmd_t;

    // periods per symbol, all entries even so the tone splits in half.
    function automatic repeat_t repeats_for(speed_t speed, symbol_kind_t kind);
        repeat_t short_rep;
        repeat_t long_rep;
        case (speed)
            normal: begin
                short_rep = 4'd6;
                long_rep  = 4'd4;
            end
            slow: begin
                short_rep = 4'd10;
                long_rep  = 4'd6;
            end
            default: begin // fast and fast_alt.
                short_rep = 4'd4;
                long_rep  = 4'd2;
            end
        endcase
        // the gap uses the short tone count.
        return (kind == long_tone) ? long_rep : short_rep;
    endfunction

endpackage

//--- rtl/request_decode.sv
`timescale 1ns/1ps

module request_decode (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                en,
    input  logic                                confirm,
    input  logic [buzzer_pkg::num_records-1:0]  select,
    input  buzzer_pkg::count_t                  record_count,
    output buzzer_pkg::play_cmd_t               play_cmd
);

    import buzzer_pkg::*;

    logic     sel_hit;
    rec_idx_t sel_idx;
    logic     accept;
    rec_idx_t top_rec;

    // lowest select bit that points at a loaded record.
    always_comb begin
        sel_hit = 1'b0;
        sel_idx = '0;
        for (int i = num_records - 1; i >= 0; i--) begin
            if (select[i] && (i < int'(record_count))) begin
                sel_hit = 1'b1;
                sel_idx = rec_idx_t'(i);
            end
        end
    end

    assign accept  = en && (record_count != '0) && (confirm || sel_hit);
    assign top_rec = rec_idx_t'(record_count - 4'd1); // count of 8 maps to index 7.

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            play_cmd <= '0;
        end else begin
            play_cmd.start <= accept;
            if (accept) begin
                play_cmd.all_records <= confirm; // confirm wins over select.
                if (confirm) begin
                    play_cmd.first_rec <= '0;
                    play_cmd.last_rec  <= top_rec;
                end else begin
                    play_cmd.first_rec <= sel_idx;
                    play_cmd.last_rec  <= sel_idx;
                end
            end
        end
    end

    // requests arrive as single-cycle strobes, so commands never run back to back.
    start_single_cycle : assert property (
        @(posedge clk) disable iff (rst)
        play_cmd.start |=> !play_cmd.start
    );

endmodule

//--- playback/playback_sequencer.sv
`timescale 1ns/1ps

module playback_sequencer (
    input  logic                       clk,
    input  logic                       rst,
    input  buzzer_pkg::play_cmd_t      play_cmd,
    input  buzzer_pkg::record_bank_t   records,
    input  logic                       symbol_done,
    output buzzer_pkg::tone_cmd_t      tone_cmd,
    output logic                       busy
);

    import buzzer_pkg::*;

    localparam logic [2:0] gap_pos = 3'(symbols_per_record - 1);

    rec_idx_t     rec_idx;
    rec_idx_t     last_rec;
    logic [2:0]   sym_pos;
    logic         load_q;
    symbol_kind_t kind_q;

    rec_idx_t     next_rec;
    logic [2:0]   next_pos;
    symbol_kind_t next_kind;
    record_t      next_code;
    logic         last_symbol;

    assign last_symbol = (sym_pos == gap_pos) && (rec_idx == last_rec);

    // position of the symbol to issue at the next load.
    always_comb begin
        if (play_cmd.start) begin
            next_rec = play_cmd.first_rec;
            next_pos = '0;
        end else if (sym_pos == gap_pos) begin
            next_rec = rec_idx + 3'd1;
            next_pos = '0;
        end else begin
            next_rec = rec_idx;
            next_pos = sym_pos + 3'd1;
        end
    end

    always_comb begin
        next_code = records[next_rec];
        if (next_pos == gap_pos) begin
            next_kind = gap_symbol;
        end else if (next_code[code_bits - 1 - int'(next_pos)]) begin // msb first.
            next_kind = long_tone;
        end else begin
            next_kind = short_tone;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy     <= 1'b0;
            rec_idx  <= '0;
            sym_pos  <= '0;
            last_rec <= '0;
            load_q   <= 1'b0;
            kind_q   <= gap_symbol;
        end else begin
            load_q <= 1'b0;
            if (play_cmd.start) begin // a new request aborts whatever is playing.
                busy     <= 1'b1;
                rec_idx  <= next_rec;
                sym_pos  <= next_pos;
                last_rec <= play_cmd.all_records ? play_cmd.last_rec : play_cmd.first_rec;
                load_q   <= 1'b1;
                kind_q   <= next_kind;
            end else if (busy && symbol_done) begin
                if (last_symbol) begin
                    busy <= 1'b0;
                end else begin
                    rec_idx <= next_rec;
                    sym_pos <= next_pos;
                    load_q  <= 1'b1;
                    kind_q  <= next_kind;
                end
            end
        end
    end

    assign tone_cmd = '{load: load_q, kind: kind_q};

    // first_rec never exceeds last_rec, so stepping stops at the last record.
    rec_within_range : assert property (
        @(posedge clk) disable iff (rst)
        busy |-> (rec_idx <= last_rec)
    );

endmodule

//--- playback/tone_generator.sv
`timescale 1ns/1ps

module tone_generator #(
    parameter int short_period = 6,
    parameter int long_period  = 10,
    parameter int gap_period   = 12
) (
    input  logic                   clk,
    input  logic                   rst,
    input  buzzer_pkg::tone_cmd_t  tone_cmd,
    input  logic                   abort,
    input  buzzer_pkg::speed_t     speed_mode,
    output logic                   buzzer,
    output logic                   symbol_done
);

    import buzzer_pkg::*;

    localparam int max_tone   = (short_period > long_period) ? short_period : long_period;
    localparam int max_period = (gap_period > max_tone) ? gap_period : max_tone;
    localparam int per_w      = $clog2(max_period + 1);

    logic [per_w-1:0] per_cnt;
    repeat_t          rep_cnt;
    logic             active;

    logic [per_w-1:0] period_q;
    repeat_t          repeats_q;
    symbol_kind_t     kind_q;

    logic             per_last;
    logic             rep_last;

    assign per_last    = (per_cnt == period_q - 1'b1);
    assign rep_last    = (rep_cnt == repeats_q - 1'b1);
    assign symbol_done = active && per_last && rep_last;

    // symbol parameters, latched at load.
    always_ff @(posedge clk) begin
        if (tone_cmd.load) begin
            kind_q    <= tone_cmd.kind;
            repeats_q <= repeats_for(speed_mode, tone_cmd.kind);
            case (tone_cmd.kind)
                short_tone: period_q <= per_w'(short_period);
                long_tone:  period_q <= per_w'(long_period);
                default:    period_q <= per_w'(gap_period);
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active  <= 1'b0;
            per_cnt <= '0;
            rep_cnt <= '0;
        end else if (abort) begin
            active  <= 1'b0;
            per_cnt <= '0;
            rep_cnt <= '0;
        end else if (tone_cmd.load) begin
            active  <= 1'b1;
            per_cnt <= '0;
            rep_cnt <= '0;
        end else if (active) begin
            if (per_last) begin
                per_cnt <= '0;
                if (rep_last) begin
                    rep_cnt <= '0;
                    active  <= 1'b0; // symbol finished.
                end else begin
                    rep_cnt <= rep_cnt + 1'b1;
                end
            end else begin
                per_cnt <= per_cnt + 1'b1;
            end
        end
    end

    // sound in the first half of the repeats, high for half of each period.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            buzzer <= 1'b0;
        end else begin
            buzzer <= active && (kind_q != gap_symbol)
                      && (rep_cnt < (repeats_q >> 1))
                      && (per_cnt < (period_q >> 1));
        end
    end

    // a gap stays silent from its load to its end.
    gap_is_silent : assert property (
        @(posedge clk) disable iff (rst)
        (tone_cmd.load && (tone_cmd.kind == gap_symbol))
            |=> (!buzzer) until_with (symbol_done || abort)
    );

endmodule

//--- rtl/code_buzzer.sv
`timescale 1ns/1ps

module code_buzzer #(
    parameter int short_period = 6,
    parameter int long_period  = 10,
    parameter int gap_period   = 12
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               en,
    input  logic                               confirm,
    input  logic [buzzer_pkg::num_records-1:0] select,
    input  buzzer_pkg::count_t                 record_count,
    input  buzzer_pkg::record_bank_t           records,
    input  buzzer_pkg::speed_t                 speed_mode,
    output logic                               buzzer,
    output logic                               busy
);

    import buzzer_pkg::*;

    play_cmd_t play_cmd;
    tone_cmd_t tone_cmd;
    logic      symbol_done;

    request_decode u_request_decode (
        .clk          (clk),
        .rst          (rst),
        .en           (en),
        .confirm      (confirm),
        .select       (select),
        .record_count (record_count),
        .play_cmd     (play_cmd)
    );

    playback_sequencer u_playback_sequencer (
        .clk         (clk),
        .rst         (rst),
        .play_cmd    (play_cmd),
        .records     (records),
        .symbol_done (symbol_done),
        .tone_cmd    (tone_cmd),
        .busy        (busy)
    );

    // the start pulse doubles as abort for the running symbol.
    tone_generator #(
        .short_period (short_period),
        .long_period  (long_period),
        .gap_period   (gap_period)
    ) u_tone_generator (
        .clk         (clk),
        .rst         (rst),
        .tone_cmd    (tone_cmd),
        .abort       (play_cmd.start),
        .speed_mode  (speed_mode),
        .buzzer      (buzzer),
        .symbol_done (symbol_done)
    );

endmodule

//--- test/tb_code_buzzer.sv
`timescale 1ns/1ps

module tb_code_buzzer;

    import buzzer_pkg::*;

    localparam int short_period   = 6;
    localparam int long_period    = 10;
    localparam int gap_period     = 12;
    localparam int line_words     = 15;
    localparam int max_lines      = 32;
    localparam int line_budget    = 8 * 6 * 12 * 10; // worst case cycles for one trace line.
    localparam int restart_delay  = 40;
    localparam int silence_window = 200;              // longer than the longest symbol.

    logic         clk;
    logic         rst;
    logic         en;
    logic         confirm;
    logic [7:0]   select;
    count_t       record_count;
    record_bank_t records;
    speed_t       speed_mode;
    logic         buzzer;
    logic         busy;

    logic [7:0]  trace_mem [0:max_lines*line_words-1];
    logic [31:0] lfsr_state;
    int          cycle_count;
    int          cycle_limit;
    int          test_errors;
    int          tests_passed;
    int          tests_failed;
    logic [63:0] exp_vec;
    logic [63:0] got_vec;
    int          exp_n;
    int          got_n;

    code_buzzer #(
        .short_period (short_period),
        .long_period  (long_period),
        .gap_period   (gap_period)
    ) DUT (
        .clk          (clk),
        .rst          (rst),
        .en           (en),
        .confirm      (confirm),
        .select       (select),
        .record_count (record_count),
        .records      (records),
        .speed_mode   (speed_mode),
        .buzzer       (buzzer),
        .busy         (busy)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("timeout after %0d cycles, the trace did not finish", cycle_count);
            $display("Regression failed");
            $finish;
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    task automatic random_record(output record_t rec);
        rec = '0;
        for (int b = 0; b < code_bits; b++) begin
            rec        = {rec[code_bits-2:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    // pulses per tone are half the repeat count.
    function automatic int tone_pulses(input logic [1:0] speed, input logic long_bit);
        case (speed)
            2'd0:    return long_bit ? 2 : 3;
            2'd1:    return long_bit ? 3 : 5;
            default: return long_bit ? 1 : 2;
        endcase
    endfunction

    task automatic report_value(input string name, input logic [63:0] exp, input logic [63:0] got);
        $display("FAIL %s exp 0x%0h got 0x%0h", name, exp, got);
        test_errors++;
    endtask

    task automatic check_idle();
        if (buzzer !== 1'b0) report_value("buzzer", 0, buzzer);
        if (busy !== 1'b0) report_value("busy", 0, busy);
    endtask

    task automatic check_silence(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #1;
            check_idle();
        end
    endtask

    task automatic apply_request(input logic c, input logic [7:0] s);
        confirm = c;
        select  = s;
        @(posedge clk);
        #1;
        confirm = 1'b0;
        select  = '0;
    endtask

    task automatic build_expected(input logic c, input logic [7:0] s);
        int      first;
        int      last;
        record_t rec;
        first   = -1;
        last    = -2;
        exp_vec = '0;
        exp_n   = 0;
        if (en && record_count != 0) begin
            if (c) begin
                first = 0;
                last  = int'(record_count) - 1;
            end else begin
                for (int i = 0; i < num_records; i++) begin
                    if (first < 0 && s[i] && i < int'(record_count)) begin
                        first = i;
                        last  = i;
                    end
                end
            end
        end
        for (int r = first; r <= last; r++) begin
            rec = records[r];
            for (int b = code_bits - 1; b >= 0; b--) begin // msb first.
                exp_vec = {exp_vec[62:0], rec[b]};
                exp_n++;
            end
        end
    endtask

    task automatic close_symbol(input int width, input int count);
        logic long_bit;
        long_bit = (width == long_period / 2);
        if (width != short_period / 2 && !long_bit) begin
            $display("FAIL pulse width exp 0x%0h or 0x%0h got 0x%0h",
                     short_period / 2, long_period / 2, width);
            test_errors++;
        end
        if (count != tone_pulses(speed_mode, long_bit)) begin
            report_value("pulse count", tone_pulses(speed_mode, long_bit), count);
        end
        got_vec = {got_vec[62:0], long_bit};
        got_n++;
    endtask

    // pulses with a short low run between them and the same width form one symbol.
    task automatic observe_playback();
        int   high_len;
        int   low_len;
        int   sym_width;
        int   sym_count;
        logic running;
        high_len  = 0;
        low_len   = 0;
        sym_width = 0;
        sym_count = 0;
        got_vec   = '0;
        got_n     = 0;
        repeat (2) @(posedge clk);
        #1;
        if (busy !== 1'b1) report_value("busy", 1, busy);
        running = 1'b1;
        while (running) begin
            @(negedge clk);
            if (buzzer === 1'b1) begin
                high_len++;
            end else begin
                if (high_len > 0) begin
                    if (sym_count > 0 && (high_len != sym_width || low_len > long_period / 2)) begin
                        close_symbol(sym_width, sym_count);
                        sym_count = 0;
                    end
                    sym_width = high_len;
                    sym_count++;
                    low_len = 0;
                end
                high_len = 0;
                low_len++;
            end
            running = (busy === 1'b1);
        end
        if (sym_count > 0) close_symbol(sym_width, sym_count);
        if (buzzer !== 1'b0) report_value("buzzer", 0, buzzer);
        @(posedge clk);
        #1;
    endtask

    task automatic finish_test(input int num, input string what);
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %0d %s: ok", num, what);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", num, what, test_errors);
        end
        test_errors = 0;
    endtask

    initial begin
        int         n_lines;
        int         base;
        int         kind;
        logic       c;
        logic [7:0] s;
        record_t    rec;
        string      what;
        clk          = 1'b0;
        rst          = 1'b1;
        en           = 1'b0;
        confirm      = 1'b0;
        select       = '0;
        record_count = '0;
        records      = '0;
        speed_mode   = normal;
        lfsr_state   = 32'hedfd_298e;
        cycle_count  = 0;
        cycle_limit  = 0;
        test_errors  = 0;
        tests_passed = 0;
        tests_failed = 0;
        $readmemh("test/code_trace.txt", trace_mem);
        n_lines = 0;
        while (n_lines < max_lines && !$isunknown(trace_mem[n_lines*line_words])) begin
            n_lines++;
        end
        cycle_limit = n_lines * line_budget + 2000;

        repeat (10) begin
            @(posedge clk);
            #1;
            check_idle();
        end
        rst = 1'b0;
        check_silence(5);
        finish_test(0, "reset state");

        for (int t = 0; t < n_lines; t++) begin
            base         = t * line_words;
            kind         = trace_mem[base];
            en           = trace_mem[base+1][0];
            record_count = count_t'(trace_mem[base+2]);
            speed_mode   = speed_t'(trace_mem[base+3][1:0]);
            c            = trace_mem[base+4][0];
            s            = trace_mem[base+5];
            for (int r = 0; r < num_records; r++) begin
                if (trace_mem[base+6][0]) begin
                    random_record(rec);
                end else begin
                    rec = record_t'(trace_mem[base+7+r]);
                end
                records[r] = rec;
            end
            if (kind == 1) begin
                apply_request(1'b1, 8'h00);
                repeat (restart_delay) @(posedge clk);
                #1;
                if (busy !== 1'b1) report_value("busy", 1, busy);
                c = 1'b0; // the select now preempts the confirm playback.
            end
            build_expected(c, s);
            apply_request(c, s);
            if (exp_n > 0) begin
                observe_playback();
                if (got_n != exp_n) report_value("buzzer symbol count", exp_n, got_n);
                if (got_vec != exp_vec) report_value("buzzer bits", exp_vec, got_vec);
            end else begin
                check_silence(silence_window);
            end
            what = (kind == 1) ? "restart" : ((exp_n > 0) ? "playback" : "ignored request");
            finish_test(t + 1, what);
        end

        $display("tests run %0d, passed %0d, failed %0d",
                 tests_passed + tests_failed, tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- test/code_trace.txt
// columns: kind en count speed confirm select rnd rec0 rec1 rec2 rec3 rec4 rec5 rec6 rec7 (hex)
// kind 1 plays a confirm first, then the select vector restarts it; rnd 1 takes lfsr records
00 01 03 00 01 00 00 15 0a 1f 00 03 04 05 06
00 01 08 01 01 00 00 11 02 1c 07 19 0e 13 08
00 01 04 02 00 0c 00 01 1e 16 09 0f 10 12 14
00 01 02 03 00 0c 00 0b 0c 0d 0e 0f 10 11 12
00 01 05 03 00 30 00 00 00 00 00 1a 05 00 00
00 00 03 00 01 00 00 15 0a 1f 00 00 00 00 00
00 01 00 00 01 ff 00 1f 1f 1f 1f 1f 1f 1f 1f
00 01 06 00 01 00 01 00 00 00 00 00 00 00 00
00 01 08 02 01 ff 01 00 00 00 00 00 00 00 00
00 01 01 01 00 01 00 1f 00 00 00 00 00 00 00
00 01 07 03 00 c0 01 00 00 00 00 00 00 00 00
00 01 03 02 00 00 00 05 06 07 00 00 00 00 00
01 01 04 00 01 04 00 13 0d 1b 04 00 00 00 00
01 01 08 01 01 81 01 00 00 00 00 00 00 00 00
00 01 08 00 00 80 00 01 02 03 04 05 06 07 18

//--- tb.f
common/buzzer_pkg.sv
rtl/request_decode.sv
playback/playback_sequencer.sv
playback/tone_generator.sv
rtl/code_buzzer.sv
test/tb_code_buzzer.sv
